// ==== verilog.f ====
+incdir+include
src/raster_if_pkg.sv
src/raster_if_intf.sv
src/stream_slice.sv
src/cmd_decoder.sv
src/dma_writer.sv
src/fb_swap_ctrl.sv
src/raster_if_top.sv
sim/raster_if_sva.sv
sim/raster_if_tb.sv

// ==== Bender.yml ====
package:
  name: raster_if

export_include_dirs:
  - include

sources:
  - src/raster_if_pkg.sv
  - src/raster_if_intf.sv
  - src/stream_slice.sv
  - src/cmd_decoder.sv
  - src/dma_writer.sv
  - src/fb_swap_ctrl.sv
  - src/raster_if_top.sv
  - target: simulation
    files:
      - sim/raster_if_sva.sv
      - sim/raster_if_tb.sv

// ==== sim/raster_if_tb.sv ====
/*
 * Testbench for the graphics command front end. Sends a random command list,
 * answers the memory, forward and display ports with random delays and
 * compares every memory beat, forward beat and swap with a reference model.
 */
`timescale 1ns/100ps
`include "raster_if_cfg.svh"

module raster_if_tb;
    localparam int NUM_COMMANDS = 24;

    logic                                   aclk;
    logic                                   reset;
    logic                                   s_cmd_axis_tvalid;
    logic                                   s_cmd_axis_tready;
    logic                                   s_cmd_axis_tlast;
    logic [`RIF_CMD_WIDTH - 1 : 0]          s_cmd_axis_tdata;
    logic                                   m_cmd_axis_tvalid;
    logic                                   m_cmd_axis_tready;
    logic                                   m_cmd_axis_tlast;
    logic [`RIF_CMD_WIDTH - 1 : 0]          m_cmd_axis_tdata;
    logic                                   mem_valid;
    logic                                   mem_ready;
    logic [`RIF_ADDR_WIDTH - 1 : 0]         mem_addr;
    logic [`RIF_CMD_WIDTH - 1 : 0]          mem_data;
    logic [`RIF_ADDR_WIDTH - 1 : 0]         fb_addr;
    logic [`RIF_FB_SIZE_WIDTH - 1 : 0]      fb_size;
    logic                                   swap_fb;
    logic                                   swap_fb_enable_vsync;
    logic                                   fb_swapped;

    logic [`RIF_CMD_WIDTH - 1 : 0]          cmd_words[$];
    logic [63 : 0]                          exp_mem[$];
    logic [32 : 0]                          exp_fwd[$];
    // Per swap: memory beats before it, vsync, fb_size and fb_addr
    logic [63 : 0]                          exp_swap[$];
    logic [`RIF_ADDR_WIDTH - 1 : 0]         final_fb_addr;
    logic [`RIF_FB_SIZE_WIDTH - 1 : 0]      final_fb_size;
    int                                     mem_seen = 0;
    int                                     cycles = 0;
    int                                     timeout_limit = 1000;
    logic                                   swap_prev = 1'b0;

    raster_if_top UUT (.*);

    initial
    begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63 : 0] expected, logic [63 : 0] actual);
        if (expected !== actual)
        begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            abort_run("Value mismatch");
        end
    endtask

    // Random mix of commands with every kind among the first five
    // A full STORE runs straight into the first SWAP_FB
    // The sixth command is an empty STORE
    function automatic void build_commands();
        int kind;
        int n;
        logic [3 : 0] op;
        for (int c = 0; c < NUM_COMMANDS; c++)
        begin
            kind = (c < 5) ? c : (c == 5) ? 0 : $urandom_range(0, 4);
            n = (c == 0) ? 8 : (c == 5) ? 0 : $urandom_range(0, 8);
            case (kind)
                0, 2:
                begin
                    op = (kind == 0) ? 4'(raster_if_pkg::STORE) : 4'(raster_if_pkg::FORWARD);
                    cmd_words.push_back({op, 12'h000, 16'(n)});
                    if (kind == 0)
                    begin
                        cmd_words.push_back($urandom & 32'hffff_fffc);
                    end
                    for (int k = 0; k < n; k++)
                    begin
                        cmd_words.push_back($urandom);
                    end
                end
                1:
                    cmd_words.push_back({4'(raster_if_pkg::SWAP_FB), 28'($urandom)});
                3:
                begin
                    cmd_words.push_back({4'(raster_if_pkg::SET_FB), 28'($urandom)});
                    cmd_words.push_back($urandom);
                end
                default:
                begin
                    // Opcode 0 or one of the unused codes 5 to 15
                    op = ($urandom_range(0, 1) == 1) ? 4'($urandom_range(5, 15)) : 4'd0;
                    cmd_words.push_back({op, 28'($urandom)});
                end
            endcase
        end
    endfunction

    // Reference model of the command format, fills the expected queues
    function automatic void build_expected();
        int i;
        int n;
        int beats;
        logic [`RIF_CMD_WIDTH - 1 : 0] hdr;
        logic [`RIF_ADDR_WIDTH - 1 : 0] addr;
        i = 0;
        beats = 0;
        final_fb_addr = '0;
        final_fb_size = '0;
        while (i < cmd_words.size())
        begin
            hdr = cmd_words[i];
            n = hdr[`RIF_COUNT_WIDTH - 1 : 0];
            case (hdr[`RIF_OPCODE_MSB : `RIF_OPCODE_LSB])
                raster_if_pkg::STORE:
                begin
                    addr = cmd_words[i + 1];
                    for (int k = 0; k < n; k++)
                    begin
                        exp_mem.push_back({32'(addr + k * `RIF_WORD_BYTES), cmd_words[i + 2 + k]});
                    end
                    beats += n;
                    i += n + 2;
                end
                raster_if_pkg::FORWARD:
                begin
                    for (int k = 0; k < n; k++)
                    begin
                        exp_fwd.push_back({cmd_words[i + 1 + k], k == n - 1});
                    end
                    i += n + 1;
                end
                raster_if_pkg::SET_FB:
                begin
                    final_fb_size = hdr[`RIF_FB_SIZE_WIDTH - 1 : 0];
                    final_fb_addr = cmd_words[i + 1];
                    i += 2;
                end
                raster_if_pkg::SWAP_FB:
                begin
                    exp_swap.push_back({11'(beats), hdr[`RIF_VSYNC_BIT], final_fb_size,
                                        final_fb_addr});
                    i += 1;
                end
                default:
                    i += 1;
            endcase
        end
    endfunction

    // Each word is held until accepted, with an idle cycle now and then
    task automatic send_commands();
        foreach (cmd_words[i])
        begin
            if ($urandom_range(0, 3) == 0)
            begin
                s_cmd_axis_tvalid = 1'b0;
                @(negedge aclk);
            end
            s_cmd_axis_tvalid = 1'b1;
            s_cmd_axis_tdata = cmd_words[i];
            s_cmd_axis_tlast = 1'($urandom);
            @(posedge aclk);
            while (!s_cmd_axis_tready)
                @(posedge aclk);
            @(negedge aclk);
        end
        s_cmd_axis_tvalid = 1'b0;
    endtask

    initial
    begin
        mem_ready = 1'b0;
        m_cmd_axis_tready = 1'b0;
        forever
        begin
            @(negedge aclk);
            mem_ready = !reset && ($urandom_range(0, 2) != 0);
            m_cmd_axis_tready = !reset && ($urandom_range(0, 3) != 0);
        end
    end

    // Display side of the four-phase swap with random delays
    initial
    begin
        fb_swapped = 1'b0;
        forever
        begin
            @(posedge aclk);
            if (swap_fb)
            begin
                repeat ($urandom_range(1, 6)) @(negedge aclk);
                fb_swapped = 1'b1;
                do
                    @(posedge aclk);
                while (swap_fb);
                repeat ($urandom_range(1, 6)) @(negedge aclk);
                fb_swapped = 1'b0;
            end
        end
    end

    always @(posedge aclk)
    begin
        cycles++;
        if (cycles > timeout_limit)
        begin
            abort_run($sformatf("Timeout after %0d cycles, outputs still missing", cycles));
        end
        if (!reset)
        begin
            if (mem_valid && mem_ready)
            begin
                if (exp_mem.size() == 0)
                    abort_run("Memory write seen with no STORE beat left");
                else
                    check_value("store beat", exp_mem.pop_front(), {mem_addr, mem_data});
                mem_seen++;
            end
            if (m_cmd_axis_tvalid && m_cmd_axis_tready)
            begin
                if (exp_fwd.size() == 0)
                    abort_run("Forward beat seen with no FORWARD word left");
                else
                    check_value("forward beat", exp_fwd.pop_front(),
                                {m_cmd_axis_tdata, m_cmd_axis_tlast});
            end
            if (swap_fb && !swap_prev)
            begin
                if (exp_swap.size() == 0)
                    abort_run("Framebuffer swap seen with no SWAP_FB left");
                else
                    check_value("swap", exp_swap.pop_front(),
                                {11'(mem_seen), swap_fb_enable_vsync, fb_size, fb_addr});
            end
            swap_prev = swap_fb;
        end
    end

    initial
    begin
        void'($urandom(88));
        reset = 1'b1;
        s_cmd_axis_tvalid = 1'b0;
        s_cmd_axis_tlast = 1'b0;
        s_cmd_axis_tdata = '0;
        build_commands();
        build_expected();
        timeout_limit = 40 * cmd_words.size() + 200;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        check_value("reset outputs", 64'h0, 64'({s_cmd_axis_tready, m_cmd_axis_tvalid,
                    mem_valid, swap_fb, fb_addr, fb_size}));
        send_commands();
        while (exp_mem.size() != 0 || exp_fwd.size() != 0 || exp_swap.size() != 0)
            @(posedge aclk);
        // A few more cycles to catch extra beats
        repeat (20) @(posedge aclk);
        check_value("final fb_addr", final_fb_addr, fb_addr);
        check_value("final fb_size", final_fb_size, fb_size);
        // The decoder is back at a header and the last swap has finished
        if (!s_cmd_axis_tready || swap_fb || mem_valid || m_cmd_axis_tvalid)
        begin
            abort_run("DUT still busy after the last command");
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== sim/raster_if_sva.sv ====
/*
 * Handshake assertions for the command front end, bound to the top level.
 * Covers payload stability on the streams and the display swap rules.
 */
`timescale 1ns/100ps
`include "raster_if_cfg.svh"

module raster_if_sva
(
    input logic                             aclk,
    input logic                             reset,
    input logic                             mem_valid,
    input logic                             mem_ready,
    input logic [`RIF_ADDR_WIDTH - 1 : 0]   mem_addr,
    input logic [`RIF_CMD_WIDTH - 1 : 0]    mem_data,
    input logic                             m_cmd_axis_tvalid,
    input logic                             m_cmd_axis_tready,
    input logic                             m_cmd_axis_tlast,
    input logic [`RIF_CMD_WIDTH - 1 : 0]    m_cmd_axis_tdata,
    input logic                             swap_fb,
    input logic                             fb_swapped
);
    mem_hold: assert property (@(posedge aclk) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable({mem_addr, mem_data}))
        else $error("Memory beat dropped or changed before mem_ready");

    fwd_hold: assert property (@(posedge aclk) disable iff (reset)
        m_cmd_axis_tvalid && !m_cmd_axis_tready
        |=> m_cmd_axis_tvalid && $stable({m_cmd_axis_tdata, m_cmd_axis_tlast}))
        else $error("Forward beat dropped or changed before tready");

    swap_hold: assert property (@(posedge aclk) disable iff (reset)
        swap_fb && !fb_swapped |=> swap_fb)
        else $error("swap_fb fell before fb_swapped");

    // The fence keeps the memory port empty when a swap starts
    swap_fence: assert property (@(posedge aclk) disable iff (reset)
        $rose(swap_fb) |-> !mem_valid)
        else $error("swap_fb rose while a memory write was pending");

endmodule

bind raster_if_top raster_if_sva sva_inst (.*);

// ==== src/raster_if_top.sv ====
/*
 * Top level of the graphics command front end. Connects the decoder,
 * the DMA writer and the swap controller to the command, forward,
 * memory and display ports.
 */
`timescale 1ns/100ps
`include "raster_if_cfg.svh"

module raster_if_top
(
    input  logic                                aclk,
    input  logic                                reset,

    // Command stream in, tlast carries no meaning for the parser
    input  logic                                s_cmd_axis_tvalid,
    output logic                                s_cmd_axis_tready,
    input  logic                                s_cmd_axis_tlast,
    input  logic [`RIF_CMD_WIDTH - 1 : 0]       s_cmd_axis_tdata,

    // Forwarded commands towards the rasterizer core
    output logic                                m_cmd_axis_tvalid,
    input  logic                                m_cmd_axis_tready,
    output logic                                m_cmd_axis_tlast,
    output logic [`RIF_CMD_WIDTH - 1 : 0]       m_cmd_axis_tdata,

    output logic                                mem_valid,
    input  logic                                mem_ready,
    output logic [`RIF_ADDR_WIDTH - 1 : 0]      mem_addr,
    output logic [`RIF_CMD_WIDTH - 1 : 0]       mem_data,

    output logic [`RIF_ADDR_WIDTH - 1 : 0]      fb_addr,
    output logic [`RIF_FB_SIZE_WIDTH - 1 : 0]   fb_size,
    output logic                                swap_fb,
    output logic                                swap_fb_enable_vsync,
    input  logic                                fb_swapped
);
    logic writes_idle;

    dma_stream_if dma_link ();
    fb_ctrl_if fb_link ();

    cmd_decoder decoder (
        .aclk(aclk),
        .reset(reset),
        .cmd_valid(s_cmd_axis_tvalid),
        .cmd_ready(s_cmd_axis_tready),
        .cmd_data(s_cmd_axis_tdata),
        .fwd_valid(m_cmd_axis_tvalid),
        .fwd_ready(m_cmd_axis_tready),
        .fwd_data(m_cmd_axis_tdata),
        .fwd_last(m_cmd_axis_tlast),
        .dma(dma_link.source),
        .fb(fb_link.ctrl)
    );

    dma_writer dma (
        .aclk(aclk),
        .reset(reset),
        .dma(dma_link.sink),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .mem_addr(mem_addr),
        .mem_data(mem_data),
        .writes_idle(writes_idle)
    );

    fb_swap_ctrl swap_ctrl (
        .aclk(aclk),
        .reset(reset),
        .fb(fb_link.unit),
        .writes_idle(writes_idle),
        .fb_addr(fb_addr),
        .fb_size(fb_size),
        .swap_fb(swap_fb),
        .swap_fb_enable_vsync(swap_fb_enable_vsync),
        .fb_swapped(fb_swapped)
    );

endmodule

// ==== src/fb_swap_ctrl.sv ====
/*
 * Framebuffer registers and swap sequencing. A swap request waits until
 * all earlier memory writes are out, then runs the four-phase handshake
 * with the display before acknowledging the decoder.
 */
`timescale 1ns/100ps
`include "raster_if_cfg.svh"

module fb_swap_ctrl
(
    input  logic                                aclk,
    input  logic                                reset,

    fb_ctrl_if.unit                             fb,
    input  logic                                writes_idle,

    output logic [`RIF_ADDR_WIDTH - 1 : 0]      fb_addr,
    output logic [`RIF_FB_SIZE_WIDTH - 1 : 0]   fb_size,
    output logic                                swap_fb,
    output logic                                swap_fb_enable_vsync,
    input  logic                                fb_swapped
);
    typedef enum logic [2 : 0]
    {
        SW_IDLE,
        SW_FENCE,
        SW_SWAPPING,
        SW_RELEASE,
        SW_ACK
    } swap_state_e;

    swap_state_e state;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            fb_addr <= '0;
            fb_size <= '0;
        end
        else if (fb.set_fb)
        begin
            fb_addr <= fb.fb_addr;
            fb_size <= fb.fb_size;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state <= SW_IDLE;
            swap_fb <= 1'b0;
            fb.swap_ack <= 1'b0;
        end
        else
        begin
            case (state)
                SW_IDLE:
                    if (fb.swap_req)
                    begin
                        state <= SW_FENCE;
                    end
                SW_FENCE:
                    // Display must have released the previous swap as well
                    if (writes_idle && !fb_swapped)
                    begin
                        swap_fb <= 1'b1;
                        state <= SW_SWAPPING;
                    end
                SW_SWAPPING:
                    if (fb_swapped)
                    begin
                        swap_fb <= 1'b0;
                        state <= SW_RELEASE;
                    end
                SW_RELEASE:
                begin
                    fb.swap_ack <= 1'b1;
                    state <= SW_ACK;
                end
                default:
                    if (!fb.swap_req)
                    begin
                        fb.swap_ack <= 1'b0;
                        state <= SW_IDLE;
                    end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == SW_IDLE && fb.swap_req)
        begin
            swap_fb_enable_vsync <= fb.swap_vsync;
        end
    end

endmodule

// ==== src/dma_writer.sv ====
/*
 * DMA writer for STORE. The first word of each block is the start
 * address, every following word becomes one addressed memory write.
 */
`timescale 1ns/100ps
`include "raster_if_cfg.svh"

module dma_writer
(
    input  logic                            aclk,
    input  logic                            reset,

    dma_stream_if.sink                      dma,

    output logic                            mem_valid,
    input  logic                            mem_ready,
    output logic [`RIF_ADDR_WIDTH - 1 : 0]  mem_addr,
    output logic [`RIF_CMD_WIDTH - 1 : 0]   mem_data,

    output logic                            writes_idle
);
    logic                               expect_addr;
    logic [`RIF_ADDR_WIDTH - 1 : 0]     addr_q;
    logic                               beat_valid;
    logic                               beat_ready;
    raster_if_pkg::mem_beat_t           beat_in;
    raster_if_pkg::mem_beat_t           beat_out;

    // The address word is swallowed here and never reaches the port
    assign dma.ready = expect_addr || beat_ready;
    assign beat_valid = dma.valid && !expect_addr;
    assign beat_in.addr = addr_q;
    assign beat_in.data = dma.data;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            expect_addr <= 1'b1;
        end
        else if (dma.valid && dma.ready)
        begin
            expect_addr <= dma.last;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (dma.valid && dma.ready)
        begin
            addr_q <= expect_addr ? dma.data[`RIF_ADDR_WIDTH - 1 : 0]
                                  : addr_q + `RIF_ADDR_WIDTH'(`RIF_WORD_BYTES);
        end
    end

    stream_slice #(
        .payload_t(raster_if_pkg::mem_beat_t)
    ) mem_slice (
        .aclk(aclk),
        .reset(reset),
        .in_valid(beat_valid),
        .in_ready(beat_ready),
        .in_data(beat_in),
        .out_valid(mem_valid),
        .out_ready(mem_ready),
        .out_data(beat_out)
    );

    assign mem_addr = beat_out.addr;
    assign mem_data = beat_out.data;

    // Nothing at the port and the skid entry empty
    assign writes_idle = !mem_valid && beat_ready;

endmodule

// ==== src/cmd_decoder.sv ====
/*
 * Command stream parser. Reads a header word, then steers the payload
 * words of STORE to the DMA writer, of FORWARD to the rasterizer stream
 * and of SET_FB / SWAP_FB to the framebuffer swap controller.
 */
`timescale 1ns/100ps
`include "raster_if_cfg.svh"

module cmd_decoder
(
    input  logic                            aclk,
    input  logic                            reset,

    input  logic                            cmd_valid,
    output logic                            cmd_ready,
    input  logic [`RIF_CMD_WIDTH - 1 : 0]   cmd_data,

    output logic                            fwd_valid,
    input  logic                            fwd_ready,
    output logic [`RIF_CMD_WIDTH - 1 : 0]   fwd_data,
    output logic                            fwd_last,

    dma_stream_if.source                    dma,
    fb_ctrl_if.ctrl                         fb
);
    typedef enum logic [2 : 0]
    {
        ST_HEADER,
        ST_STORE_ADDR,
        ST_STORE_DATA,
        ST_FWD_DATA,
        ST_FB_ADDR,
        ST_SWAP_WAIT
    } state_e;

    state_e                             state;
    logic                               active;
    logic [`RIF_COUNT_WIDTH - 1 : 0]    count;
    logic [`RIF_FB_SIZE_WIDTH - 1 : 0]  size_q;
    raster_if_pkg::opcode_e             opcode;
    logic                               cmd_fire;
    logic                               fwd_in_valid;
    logic                               fwd_in_ready;
    raster_if_pkg::fwd_beat_t           fwd_in;
    raster_if_pkg::fwd_beat_t           fwd_out;

    assign opcode = raster_if_pkg::opcode_e'(cmd_data[`RIF_OPCODE_MSB : `RIF_OPCODE_LSB]);
    assign cmd_fire = cmd_valid && cmd_ready;

    // Payload words wait on their destination, the swap blocks everything
    always_comb
    begin
        case (state)
            ST_HEADER:      cmd_ready = active;
            ST_STORE_ADDR:  cmd_ready = dma.ready;
            ST_STORE_DATA:  cmd_ready = dma.ready;
            ST_FWD_DATA:    cmd_ready = fwd_in_ready;
            ST_FB_ADDR:     cmd_ready = 1'b1;
            default:        cmd_ready = 1'b0;
        endcase
    end

    assign dma.valid = cmd_valid && (state == ST_STORE_ADDR || state == ST_STORE_DATA);
    assign dma.data = cmd_data;
    // An empty STORE closes with its address word
    assign dma.last = (state == ST_STORE_ADDR) ? (count == '0) : (count == 1);

    assign fwd_in_valid = cmd_valid && (state == ST_FWD_DATA);
    assign fwd_in.data = cmd_data;
    assign fwd_in.last = (count == 1);

    assign fb.set_fb = cmd_valid && (state == ST_FB_ADDR);
    assign fb.fb_addr = cmd_data[`RIF_ADDR_WIDTH - 1 : 0];
    assign fb.fb_size = size_q;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state <= ST_HEADER;
            active <= 1'b0;
            count <= '0;
            fb.swap_req <= 1'b0;
        end
        else
        begin
            active <= 1'b1;
            case (state)
                ST_HEADER:
                begin
                    if (cmd_fire)
                    begin
                        count <= cmd_data[`RIF_COUNT_WIDTH - 1 : 0];
                        case (opcode)
                            raster_if_pkg::STORE:
                                state <= ST_STORE_ADDR;
                            raster_if_pkg::FORWARD:
                                if (cmd_data[`RIF_COUNT_WIDTH - 1 : 0] != '0)
                                begin
                                    state <= ST_FWD_DATA;
                                end
                            raster_if_pkg::SET_FB:
                                state <= ST_FB_ADDR;
                            raster_if_pkg::SWAP_FB:
                            begin
                                state <= ST_SWAP_WAIT;
                                fb.swap_req <= 1'b1;
                            end
                            default:
                                state <= ST_HEADER;
                        endcase
                    end
                end
                ST_STORE_ADDR:
                begin
                    if (cmd_fire)
                    begin
                        state <= (count == '0) ? ST_HEADER : ST_STORE_DATA;
                    end
                end
                ST_STORE_DATA, ST_FWD_DATA:
                begin
                    if (cmd_fire)
                    begin
                        count <= count - 1'b1;
                        if (count == 1)
                        begin
                            state <= ST_HEADER;
                        end
                    end
                end
                ST_FB_ADDR:
                begin
                    if (cmd_fire)
                    begin
                        state <= ST_HEADER;
                    end
                end
                default:
                begin
                    // Drop the request on ack, leave once ack has fallen
                    if (fb.swap_ack)
                    begin
                        fb.swap_req <= 1'b0;
                    end
                    else if (!fb.swap_req)
                    begin
                        state <= ST_HEADER;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == ST_HEADER && cmd_fire)
        begin
            size_q <= cmd_data[`RIF_FB_SIZE_WIDTH - 1 : 0];
            fb.swap_vsync <= cmd_data[`RIF_VSYNC_BIT];
        end
    end

    stream_slice #(
        .payload_t(raster_if_pkg::fwd_beat_t)
    ) fwd_slice (
        .aclk(aclk),
        .reset(reset),
        .in_valid(fwd_in_valid),
        .in_ready(fwd_in_ready),
        .in_data(fwd_in),
        .out_valid(fwd_valid),
        .out_ready(fwd_ready),
        .out_data(fwd_out)
    );

    assign fwd_data = fwd_out.data;
    assign fwd_last = fwd_out.last;

endmodule

// ==== src/stream_slice.sv ====
/*
 * Two-entry valid/ready skid buffer. Output valid and input ready both
 * come from flops, and it still passes one beat per cycle.
 */
`timescale 1ns/100ps

module stream_slice #(
    parameter type payload_t = logic [31 : 0]
)
(
    input  logic        aclk,
    input  logic        reset,

    input  logic        in_valid,
    output logic        in_ready,
    input  payload_t    in_data,

    output logic        out_valid,
    input  logic        out_ready,
    output payload_t    out_data
);
    logic       skid_valid;
    payload_t   skid_data;

    // A full skid entry means the output is stalled and no more room is left
    assign in_ready = !skid_valid;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (out_ready || !out_valid)
        begin
            // Output register is free this cycle, refill from skid first
            if (skid_valid)
            begin
                out_valid <= 1'b1;
                skid_valid <= 1'b0;
            end
            else
            begin
                out_valid <= in_valid;
            end
        end
        else if (in_valid && in_ready)
        begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (out_ready || !out_valid)
        begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        else if (in_valid && in_ready)
        begin
            skid_data <= in_data;
        end
    end

endmodule

// ==== src/raster_if_intf.sv ====
/*
 * Internal links of the command front end. dma_stream_if carries STORE
 * words from the decoder to the DMA writer, fb_ctrl_if carries framebuffer
 * settings and the four-phase swap request to the swap controller.
 */
`timescale 1ns/100ps
`include "raster_if_cfg.svh"

interface dma_stream_if;
    logic                           valid;
    logic                           ready;
    logic [`RIF_CMD_WIDTH - 1 : 0]  data;
    // Marks the final word of a STORE, or its address word if empty
    logic                           last;

    modport source (output valid, output data, output last, input ready);
    modport sink (input valid, input data, input last, output ready);
endinterface

interface fb_ctrl_if;
    // One-cycle pulse, address and size are valid with it
    logic                               set_fb;
    logic [`RIF_ADDR_WIDTH - 1 : 0]     fb_addr;
    logic [`RIF_FB_SIZE_WIDTH - 1 : 0]  fb_size;
    // Four-phase request and acknowledge of a framebuffer swap
    logic                               swap_req;
    logic                               swap_vsync;
    logic                               swap_ack;

    modport ctrl
    (
        output set_fb,
        output fb_addr,
        output fb_size,
        output swap_req,
        output swap_vsync,
        input  swap_ack
    );

    modport unit
    (
        input  set_fb,
        input  fb_addr,
        input  fb_size,
        input  swap_req,
        input  swap_vsync,
        output swap_ack
    );
endinterface

// ==== src/raster_if_pkg.sv ====
/*
 * Shared types of the command front end: the opcode encoding and the
 * beat structs carried through the skid buffers. Use by scoped names.
 */
`include "raster_if_cfg.svh"

package raster_if_pkg;

    // Opcode in header bits 31..28, anything not listed decodes as a NOP
    typedef enum logic [3:0]
    {
        NOP     = 4'd0,
        STORE   = 4'd1,
        FORWARD = 4'd2,
        SET_FB  = 4'd3,
        SWAP_FB = 4'd4
    } opcode_e;

    // One addressed write on the memory port
    typedef struct packed
    {
        logic [`RIF_ADDR_WIDTH - 1 : 0] addr;
        logic [`RIF_CMD_WIDTH - 1 : 0]  data;
    } mem_beat_t;

    // One word on the stream towards the rasterizer core
    typedef struct packed
    {
        logic [`RIF_CMD_WIDTH - 1 : 0]  data;
        logic                           last;
    } fwd_beat_t;

endpackage

// ==== include/raster_if_cfg.svh ====
/*
 * Widths and field positions of the command stream format.
 * Included by the package and by every module that sizes a port.
 */
`ifndef RASTER_IF_CFG_SVH
`define RASTER_IF_CFG_SVH

`define RIF_CMD_WIDTH 32
`define RIF_ADDR_WIDTH 32
`define RIF_FB_SIZE_WIDTH 20

// Header word layout
`define RIF_OPCODE_MSB 31
`define RIF_OPCODE_LSB 28
`define RIF_VSYNC_BIT 27
`define RIF_COUNT_WIDTH 16

// Address step between two memory beats
`define RIF_WORD_BYTES 4

`endif
